//--- src/divPkg.sv
package divPkg;

   ////////////////////
   // integer level conventions

   // operand width when the top is left at its default
   parameter int DefaultWidth = 64;

   // special cases of RISC-V integer division
   typedef enum logic [1:0]
   {
      CaseNormal   = 2'd0,  // ordinary divide
      CaseDivZero  = 2'd1,  // divisor is zero
      CaseOverflow = 2'd2   // signed, most negative over minus one
   } caseT;

endpackage

//--- src/srtPkg.sv
package srtPkg;

   ////////////////////
   // radix-4 recurrence

   // integer and guard bits above the operand in the residual
   parameter int GuardBits = 4;

   // one-hot digit, bits are +2 +1 -1 -2, zero means digit 0
   typedef logic [3:0] digitT;

   localparam digitT DigitPos2 = 4'b1000;
   localparam digitT DigitPos1 = 4'b0100;
   localparam digitT DigitNeg1 = 4'b0010;
   localparam digitT DigitNeg2 = 4'b0001;
   localparam digitT DigitZero = 4'b0000;

   // truncated residual estimate, 3 integer and 4 fraction bits
   typedef logic [6:0] estimateT;

   // divisor fraction bits right below the leading one
   typedef logic [2:0] divLeadT;

   ////////////////////
   // controller

   typedef enum logic [1:0]
   {
      Idle    = 2'd0,
      Iterate = 2'd1,
      Finish  = 2'd2
   } stateT;

endpackage

//--- src/quotientSelect.sv
`timescale 1ns/1ps

module quotientSelect
(
   input  srtPkg::estimateT estimate,
   input  srtPkg::divLeadT  divLead,
   output srtPkg::digitT    digit
);

   // guard bits plus three fraction bits, in sixteenths
   localparam int EstBits = srtPkg::GuardBits + 3;

   logic signed [EstBits-1:0] est;
   logic signed [EstBits-1:0] m2;   // lower bound for +2
   logic signed [EstBits-1:0] m1;   // lower bound for +1
   logic signed [EstBits-1:0] m0;   // lower bound for 0
   logic signed [EstBits-1:0] mn1;  // lower bound for -1

   assign est = estimate;

   // thresholds per divisor interval [8+k, 9+k)/16
   always_comb
   begin
      case (divLead)
         3'd0:    begin m2 = 12; m1 = 4; m0 = -4; mn1 = -13; end
         3'd1:    begin m2 = 14; m1 = 4; m0 = -6; mn1 = -15; end
         3'd2:    begin m2 = 15; m1 = 4; m0 = -6; mn1 = -16; end
         3'd3:    begin m2 = 16; m1 = 4; m0 = -6; mn1 = -18; end
         3'd4:    begin m2 = 18; m1 = 6; m0 = -8; mn1 = -20; end
         3'd5:    begin m2 = 20; m1 = 6; m0 = -8; mn1 = -20; end
         3'd6:    begin m2 = 20; m1 = 8; m0 = -8; mn1 = -22; end
         default: begin m2 = 24; m1 = 8; m0 = -8; mn1 = -24; end
      endcase
   end

   always_comb
   begin
      if (est >= m2)
         digit = srtPkg::DigitPos2;
      else if (est >= m1)
         digit = srtPkg::DigitPos1;
      else if (est >= m0)
         digit = srtPkg::DigitZero;
      else if (est >= mn1)
         digit = srtPkg::DigitNeg1;
      else
         digit = srtPkg::DigitNeg2;  // deep negative
   end

endmodule

//--- src/otfConverter.sv
`timescale 1ns/1ps

module otfConverter #(parameter int Width = 64)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             clear,
   input  logic             enable,
   input  srtPkg::digitT    digit,
   output logic [Width-1:0] quotientQ,
   output logic [Width-1:0] quotientQM
);

   logic       qFromQM;   // negative digit borrows from Q-1
   logic       qmFromQ;   // positive digit lets Q-1 follow Q
   logic [1:0] qBits;
   logic [1:0] qmBits;
   logic [Width-1:0] qBase;
   logic [Width-1:0] qmBase;

   assign qFromQM = digit[1] | digit[0];
   assign qmFromQ = digit[3] | digit[2];

   // appended pair is q mod 4 and (q-1) mod 4
   assign qBits  = {digit[3] | digit[1] | digit[0], digit[2] | digit[1]};
   assign qmBits = {digit[1] | (digit == srtPkg::DigitZero),
                    digit[3] | digit[0] | (digit == srtPkg::DigitZero)};

   assign qBase  = qFromQM ? quotientQM : quotientQ;
   assign qmBase = qmFromQ ? quotientQ : quotientQM;

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         quotientQ  <= '0;
         quotientQM <= '0;
      end
      else if (enable)
      begin
         quotientQ  <= {qBase[Width-3:0], qBits};
         quotientQM <= {qmBase[Width-3:0], qmBits};
      end
   end

endmodule

//--- src/operandPrep.sv
`timescale 1ns/1ps

module operandPrep #(parameter int Width = 64)
(
   input  logic                     isSigned,
   input  logic [Width-1:0]         dividend,
   input  logic [Width-1:0]         divisor,
   output logic [Width-1:0]         absDividend,
   output logic [Width-1:0]         normDivisor,
   output logic [$clog2(Width)-1:0] shiftAmount,
   output logic [$clog2(Width)-1:0] iterCount,
   output logic                     oddShift,
   output logic                     negQuotient,
   output logic                     negRemainder,
   output divPkg::caseT             caseKind
);

   localparam int ShiftBits = $clog2(Width);

   logic               dividendNeg;
   logic               divisorNeg;
   logic [Width-1:0]   absDivisor;
   logic [ShiftBits:0] iterSum;

   assign dividendNeg = isSigned & dividend[Width-1];
   assign divisorNeg  = isSigned & divisor[Width-1];

   // most negative value comes out right as an unsigned magnitude
   assign absDividend = dividendNeg ? -dividend : dividend;
   assign absDivisor  = divisorNeg ? -divisor : divisor;

   ////////////////////
   // leading zeros

   always_comb
   begin
      shiftAmount = '0;  // zero divisor also ends up here
      for (int i = 0; i < Width; i++)
      begin
         if (absDivisor[i])
            shiftAmount = ShiftBits'(Width - 1 - i);  // highest one wins
      end
   end

   assign normDivisor = absDivisor << shiftAmount;
   assign oddShift    = shiftAmount[0];

   // ceil((shift + 2) / 2) digits, load cycle included
   assign iterSum   = {1'b0, shiftAmount} + (ShiftBits + 1)'(3);
   assign iterCount = iterSum[ShiftBits:1];

   assign negQuotient  = dividendNeg ^ divisorNeg;
   assign negRemainder = dividendNeg;

   ////////////////////
   // special cases

   always_comb
   begin
      if (divisor == '0)
         caseKind = divPkg::CaseDivZero;
      else if (isSigned && dividend == {1'b1, {(Width-1){1'b0}}} && &divisor)
         caseKind = divPkg::CaseOverflow;
      else
         caseKind = divPkg::CaseNormal;
   end

endmodule

//--- src/divControl.sv
`timescale 1ns/1ps

module divControl #(parameter int Width = 64)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic [$clog2(Width)-1:0] iterCount,
   output logic                     load,
   output logic                     iterEnable,
   output logic                     clearOtf,
   output logic                     busy,
   output logic                     done
);

   srtPkg::stateT            state;
   logic [$clog2(Width)-1:0] remaining;  // digits still to go

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= srtPkg::Idle;
         remaining <= '0;
      end
      else
      begin
         case (state)
            srtPkg::Idle:
            begin
               if (start)
               begin
                  state     <= srtPkg::Iterate;
                  remaining <= iterCount;
               end
            end
            srtPkg::Iterate:
            begin
               remaining <= remaining - 1'b1;
               if (remaining == 1)
                  state <= srtPkg::Finish;  // last digit this cycle
            end
            default:
               state <= srtPkg::Idle;
         endcase
      end
   end

   // start is only taken when idle
   assign load       = (state == srtPkg::Idle) & start;
   assign iterEnable = load | (state == srtPkg::Iterate);
   // converter gets cleared right as a new divide starts, results stay put
   assign clearOtf   = load;
   assign busy       = (state != srtPkg::Idle);
   assign done       = (state == srtPkg::Finish);

endmodule

//--- src/srtRecurrence.sv
`timescale 1ns/1ps

module srtRecurrence #(parameter int Width = 64)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             load,
   input  logic             iterEnable,
   input  logic             clearOtf,
   input  logic [Width-1:0] absDividend,
   input  logic [Width-1:0] normDivisor,
   input  logic             oddShift,
   output logic [Width-1:0] quotientRaw,
   output logic [Width-1:0] remainderScaled
);

   localparam int ResBits = Width + srtPkg::GuardBits;

   logic [ResBits-1:0] sumReg;
   logic [ResBits-1:0] carryReg;
   logic               firstIter;
   logic [ResBits-1:0] seed;
   logic [ResBits-1:0] sumIn;
   logic [ResBits-1:0] carryIn;
   logic [ResBits-1:0] divOne;
   logic [ResBits-1:0] divTwo;
   logic [ResBits-1:0] multiple;
   logic [ResBits-1:0] addend;
   logic [ResBits-1:0] majority;
   logic [ResBits-1:0] sumNext;
   logic [ResBits-1:0] carryNext;
   logic [7:0]         estSum;
   logic               ulp;
   srtPkg::digitT      digit;
   logic [Width-1:0]   quotientQ;
   logic [Width-1:0]   quotientQM;
   logic [ResBits-1:0] resid;
   logic [ResBits-1:0] residFixed;

   // divisor sits as a fraction in [1/2, 1), one unit at bit Width+1
   assign divOne = {{(srtPkg::GuardBits-1){1'b0}}, normDivisor, 1'b0};
   assign divTwo = {{(srtPkg::GuardBits-2){1'b0}}, normDivisor, 2'b00};

   // odd shift keeps the dividend low so the last digit lands on bit 0
   assign seed = oddShift ? {{srtPkg::GuardBits{1'b0}}, absDividend}
                          : {{(srtPkg::GuardBits-1){1'b0}}, absDividend, 1'b0};

   ////////////////////
   // digit selection

   // seed is used unshifted on the first digit
   assign sumIn   = firstIter ? sumReg : {sumReg[ResBits-3:0], 2'b00};
   assign carryIn = firstIter ? carryReg : {carryReg[ResBits-3:0], 2'b00};

   assign estSum = sumIn[ResBits-1:ResBits-8] + carryIn[ResBits-1:ResBits-8];

   quotientSelect qsel
   (
      .estimate(estSum[7:1]),
      .divLead(normDivisor[Width-2:Width-4]),
      .digit(digit)
   );

   always_comb
   begin
      case (digit)
         srtPkg::DigitPos2: multiple = ~divTwo;
         srtPkg::DigitPos1: multiple = ~divOne;
         srtPkg::DigitNeg1: multiple = divOne;
         srtPkg::DigitNeg2: multiple = divTwo;
         default:           multiple = '0;
      endcase
   end

   assign ulp = digit[3] | digit[2];  // finishes the two's complement

   ////////////////////
   // carry-save step

   assign addend    = {carryIn[ResBits-1:1], ulp};
   assign sumNext   = multiple ^ sumIn ^ addend;
   assign majority  = (multiple & sumIn) | (multiple & addend) | (sumIn & addend);
   assign carryNext = {majority[ResBits-2:0], 1'b0};

   always_ff @(posedge clk)
   begin
      if (iterEnable)
      begin
         if (load)
         begin
            sumReg   <= seed;
            carryReg <= '0;
         end
         else
         begin
            sumReg   <= sumNext;
            carryReg <= carryNext;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         firstIter <= 1'b0;
      else
         firstIter <= load;
   end

   otfConverter #(.Width(Width)) otf
   (
      .clk(clk), .reset(reset), .clear(clearOtf),
      .enable(iterEnable & ~load), .digit(digit),
      .quotientQ(quotientQ), .quotientQM(quotientQM)
   );

   ////////////////////
   // final correction

   assign resid      = sumReg + carryReg;
   assign residFixed = resid + divOne;  // add back one divisor

   // residual holds the remainder times 2^(shift+1)
   assign remainderScaled = resid[ResBits-1] ? residFixed[Width:1] : resid[Width:1];
   assign quotientRaw     = resid[ResBits-1] ? quotientQM : quotientQ;

endmodule

//--- src/resultFixup.sv
`timescale 1ns/1ps

module resultFixup #(parameter int Width = 64)
(
   input  logic [Width-1:0]         quotientRaw,
   input  logic [Width-1:0]         remainderScaled,
   input  logic [$clog2(Width)-1:0] shiftAmount,
   input  logic                     negQuotient,
   input  logic                     negRemainder,
   input  divPkg::caseT             caseKind,
   input  logic [Width-1:0]         dividend,
   output logic [Width-1:0]         quotient,
   output logic [Width-1:0]         remainder
);

   logic [Width-1:0] remainderAbs;
   logic [Width-1:0] quotientSigned;
   logic [Width-1:0] remainderSigned;

   // undo the divisor normalization
   assign remainderAbs = remainderScaled >> shiftAmount;

   assign quotientSigned  = negQuotient ? -quotientRaw : quotientRaw;
   assign remainderSigned = negRemainder ? -remainderAbs : remainderAbs;  // follows dividend

   ////////////////////
   // RISC-V special results

   always_comb
   begin
      case (caseKind)
         divPkg::CaseDivZero:
         begin
            quotient  = '1;
            remainder = dividend;
         end
         divPkg::CaseOverflow:
         begin
            quotient  = {1'b1, {(Width-1){1'b0}}};
            remainder = '0;
         end
         default:
         begin
            quotient  = quotientSigned;
            remainder = remainderSigned;
         end
      endcase
   end

endmodule

//--- src/intDivider.sv
`timescale 1ns/1ps

module intDivider #(parameter int Width = divPkg::DefaultWidth)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic             isSigned,
   input  logic [Width-1:0] dividend,
   input  logic [Width-1:0] divisor,
   output logic [Width-1:0] quotient,
   output logic [Width-1:0] remainder,
   output logic             busy,
   output logic             done,
   output logic             divZero
);

   localparam int ShiftBits = $clog2(Width);

   logic [Width-1:0]     absDividend;
   logic [Width-1:0]     normDivisor;
   logic [ShiftBits-1:0] shiftAmount;
   logic [ShiftBits-1:0] iterCount;
   logic                 oddShift;
   logic                 negQuotient;
   logic                 negRemainder;
   divPkg::caseT         caseKind;
   logic                 load;
   logic                 iterEnable;
   logic                 clearOtf;
   logic [Width-1:0]     quotientRaw;
   logic [Width-1:0]     remainderScaled;

   operandPrep #(.Width(Width)) prep
   (
      .isSigned(isSigned), .dividend(dividend), .divisor(divisor),
      .absDividend(absDividend), .normDivisor(normDivisor),
      .shiftAmount(shiftAmount), .iterCount(iterCount), .oddShift(oddShift),
      .negQuotient(negQuotient), .negRemainder(negRemainder), .caseKind(caseKind)
   );

   divControl #(.Width(Width)) ctrl
   (
      .clk(clk), .reset(reset), .start(start), .iterCount(iterCount),
      .load(load), .iterEnable(iterEnable), .clearOtf(clearOtf),
      .busy(busy), .done(done)
   );

   srtRecurrence #(.Width(Width)) recur
   (
      .clk(clk), .reset(reset), .load(load), .iterEnable(iterEnable),
      .clearOtf(clearOtf), .absDividend(absDividend), .normDivisor(normDivisor),
      .oddShift(oddShift), .quotientRaw(quotientRaw),
      .remainderScaled(remainderScaled)
   );

   resultFixup #(.Width(Width)) fixup
   (
      .quotientRaw(quotientRaw), .remainderScaled(remainderScaled),
      .shiftAmount(shiftAmount), .negQuotient(negQuotient),
      .negRemainder(negRemainder), .caseKind(caseKind), .dividend(dividend),
      .quotient(quotient), .remainder(remainder)
   );

   assign divZero = (caseKind == divPkg::CaseDivZero);

endmodule

//--- testbench/intDivider_props.sv
`timescale 1ns/1ps

module intDivider_props
(
   input logic          clk,
   input logic          reset,
   input srtPkg::stateT state,
   input logic          busy,
   input logic          done
);

   ////////////////////
   // control timing

   // done is a single-cycle pulse
   doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
      else $error("done stayed high for more than one cycle");

   // done only right after the last iteration
   doneInFinish: assert property (@(posedge clk) disable iff (reset)
      done |-> (state == srtPkg::Finish && busy && $past(state) == srtPkg::Iterate))
      else $error("done seen outside the finish state or not right after the iterations");

   busyDropsAfterDone: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
      else $error("busy still high on the edge after done");

   // quiet controller right out of reset
   quietAfterReset: assert property (@(posedge clk) reset |=> (!busy && !done))
      else $error("busy or done high in the cycle after reset");

endmodule

//--- testbench/intDividerTb.sv
`timescale 1ns/1ps

module intDividerTb;

   localparam int Width         = 32;
   localparam int ClockPeriod   = 40;
   localparam int ResetCycles   = 10;
   localparam int OpCycles      = Width / 2 + 4;  // worst case for one divide
   localparam int UnsignedPairs = 200;
   localparam int SignedPairs   = 100;
   // directed ops plus random ones, the busy test as four with its idle tail
   localparam int NumOps = 6 + UnsignedPairs + 4 + SignedPairs + 3 + 2 + 4;
   localparam longint WatchdogNs = longint'(NumOps) * OpCycles * ClockPeriod
                                   + ResetCycles * ClockPeriod;
   localparam logic [Width-1:0] MostNeg = {1'b1, {(Width-1){1'b0}}};

   logic             clk;
   logic             reset;
   logic             start;
   logic             isSigned;
   logic [Width-1:0] dividend;
   logic [Width-1:0] divisor;
   logic [Width-1:0] quotient;
   logic [Width-1:0] remainder;
   logic             busy;
   logic             done;
   logic             divZero;

   int          errorCount = 0;
   int          doneCount  = 0;
   logic [31:0] lcgState   = 32'hf3139015;

   intDivider #(.Width(Width)) UUT
   (
      .clk(clk), .reset(reset), .start(start), .isSigned(isSigned),
      .dividend(dividend), .divisor(divisor), .quotient(quotient),
      .remainder(remainder), .busy(busy), .done(done), .divZero(divZero)
   );

   bind divControl intDivider_props props
   (
      .clk(clk), .reset(reset), .state(state), .busy(busy), .done(done)
   );

   always #(ClockPeriod / 2) clk = ~clk;

   always @(posedge clk)
   begin
      if (!reset && done)
         doneCount <= doneCount + 1;  // one per finished divide
   end

   ////////////////////
   // helpers

   function logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // RISC-V division rules
   function automatic void referenceDivide(input logic [Width-1:0] a, b, input logic sgn,
                                           output logic [Width-1:0] q, r);
      if (b == '0)
      begin
         q = '1;
         r = a;
      end
      else if (sgn && a == MostNeg && b == '1)
      begin
         q = MostNeg;
         r = '0;
      end
      else if (sgn)
      begin
         q = $signed(a) / $signed(b);  // truncates toward zero
         r = $signed(a) % $signed(b);
      end
      else
      begin
         q = a / b;
         r = a % b;
      end
   endfunction

   task automatic checkValue(input string name, input logic [Width-1:0] expected, actual);
      if (expected !== actual)
      begin
         $display("[FAIL] %0t ns %s: expected %h, actual %h", $time, name, expected, actual);
         errorCount++;
      end
   endtask

   task automatic launchDivide(input logic [Width-1:0] a, b, input logic sgn);
      @(posedge clk);
      dividend <= a;
      divisor  <= b;
      isSigned <= sgn;
      start    <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic awaitDone(output logic seen, output int cycles);
      cycles = 0;
      @(negedge clk);
      while (!done && cycles < OpCycles)
      begin
         @(negedge clk);
         cycles++;
      end
      seen = done;
      if (!done)
      begin
         $display("done did not arrive within %0d cycles, at %0t ns", OpCycles, $time);
         errorCount++;
      end
   endtask

   task automatic checkResults(input logic [Width-1:0] a, b, input logic sgn);
      logic [Width-1:0] expQ;
      logic [Width-1:0] expR;
      referenceDivide(a, b, sgn, expQ, expR);
      checkValue("quotient", expQ, quotient);
      checkValue("remainder", expR, remainder);
      checkValue("divZero", Width'(b == '0), Width'(divZero));
   endtask

   // the cycle after done: controller idle, exactly one done counted
   task automatic closeOut(input int donesBefore);
      @(negedge clk);
      if (done)
      begin
         $display("done stayed high longer than one cycle, at %0t ns", $time);
         errorCount++;
      end
      checkValue("busy", '0, Width'(busy));
      if (doneCount != donesBefore + 1)
      begin
         $display("expected one done for this divide but counted %0d", doneCount - donesBefore);
         errorCount++;
      end
   endtask

   task automatic runDivide(input logic [Width-1:0] a, b, input logic sgn);
      int   donesBefore;
      int   waited;
      logic seen;
      donesBefore = doneCount;
      launchDivide(a, b, sgn);
      awaitDone(seen, waited);
      if (seen)
         checkResults(a, b, sgn);
      closeOut(donesBefore);
   endtask

   ////////////////////
   // directed tests

   task automatic resetBehavior();
      @(negedge clk);
      checkValue("busy", '0, Width'(busy));
      checkValue("done", '0, Width'(done));
   endtask

   task automatic unsignedDivision();
      logic [Width-1:0] a;
      logic [Width-1:0] b;
      runDivide(32'd100, 32'd1, 1'b0);
      runDivide(32'hffff_ffff, 32'd1, 1'b0);
      runDivide(32'd7, 32'd100, 1'b0);  // divisor above dividend
      runDivide(32'd12345, 32'd12345, 1'b0);
      runDivide(32'hffff_ffff, 32'hffff_ffff, 1'b0);
      runDivide(32'hffff_fffe, 32'hffff_ffff, 1'b0);
      for (int i = 0; i < UnsignedPairs; i++)
      begin
         a = nextRand();
         b = nextRand() >> (nextRand() % 32);  // spread the divisor sizes
         runDivide(a, b, 1'b0);
      end
   endtask

   task automatic signedDivision();
      logic [Width-1:0] a;
      logic [Width-1:0] b;
      logic [31:0]      flip;
      runDivide(32'd100, 32'd7, 1'b1);
      runDivide(-32'd100, 32'd7, 1'b1);
      runDivide(32'd100, -32'd7, 1'b1);
      runDivide(-32'd100, -32'd7, 1'b1);
      for (int i = 0; i < SignedPairs; i++)
      begin
         a    = nextRand();
         b    = nextRand() >> (nextRand() % 32);
         flip = nextRand();
         if (flip[16])
            b = -b;
         runDivide(a, b, 1'b1);
      end
   endtask

   task automatic divideByZero();
      runDivide(32'd12345, '0, 1'b0);
      runDivide(-32'd5, '0, 1'b1);
      runDivide('0, '0, 1'b0);
   endtask

   task automatic signedOverflow();
      runDivide(MostNeg, '1, 1'b1);
      runDivide(MostNeg, '1, 1'b0);  // plain unsigned divide here
   endtask

   task automatic startWhileBusy();
      int   donesBefore;
      int   plainCycles;
      int   busyCycles;
      logic seen;
      // same divide left alone first, for its length
      donesBefore = doneCount;
      launchDivide(32'hdead_beef, 32'd3, 1'b0);
      awaitDone(seen, plainCycles);
      closeOut(donesBefore);
      donesBefore = doneCount;
      launchDivide(32'hdead_beef, 32'd3, 1'b0);  // long run, divisor shift of 30
      repeat (2) @(posedge clk);
      @(negedge clk);
      checkValue("busy", Width'(1'b1), Width'(busy));
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      awaitDone(seen, busyCycles);
      if (seen)
      begin
         checkResults(32'hdead_beef, 32'd3, 1'b0);
         // a restarted divide would push done out
         checkValue("cycles to done", Width'(plainCycles - 4), Width'(busyCycles));
      end
      closeOut(donesBefore);
      repeat (Width) @(negedge clk);
      if (doneCount != donesBefore + 1)
      begin
         $display("the start pulse during busy produced an extra done");
         errorCount++;
      end
   endtask

   ////////////////////
   // main sequence

   initial
   begin
      clk      = 1'b0;
      reset    = 1'b1;
      start    = 1'b0;
      isSigned = 1'b0;
      dividend = '0;
      divisor  = '0;
      repeat (ResetCycles) @(posedge clk);
      reset <= 1'b0;
      resetBehavior();
      unsignedDivision();
      signedDivision();
      divideByZero();
      signedOverflow();
      startWhileBusy();
      $display("errors: %0d", errorCount);
      if (errorCount == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      #(WatchdogNs);
      $display("timeout, the tests ran past %0d ns without finishing", WatchdogNs);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- intDivider.f
src/divPkg.sv
src/srtPkg.sv
src/quotientSelect.sv
src/otfConverter.sv
src/operandPrep.sv
src/divControl.sv
src/srtRecurrence.sv
src/resultFixup.sv
src/intDivider.sv
testbench/intDivider_props.sv
testbench/intDividerTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module intDividerTb -f intDivider.f -o intDividerSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/intDividerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0
